/* execCluster.sv */
`timescale 1ns/10ps
`include "execCluster_settings.svh"

module execCluster (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    output logic            inReady,
    input  execPkg::issueT  inData,
    output logic            outValid,
    input  logic            outReady,
    output execPkg::resultT outData
);

    logic [`EXEC_LANES-1:0] laneInValid;
    logic [`EXEC_LANES-1:0] laneInReady;
    execPkg::issueT         laneIssue;
    logic [`EXEC_LANES-1:0] laneOutValid;
    logic [`EXEC_LANES-1:0] laneOutReady;
    execPkg::resultT        laneResult [`EXEC_LANES];

    laneDispatcher uDispatcher (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inData),
        .laneValid(laneInValid),
        .laneReady(laneInReady),
        .laneData (laneIssue)
    );

    for (genvar i = 0; i < `EXEC_LANES; i++) begin : genLane
        execLane uLane (
            .clk        (clk),
            .rstN       (rstN),
            .issueValid (laneInValid[i]),
            .issueReady (laneInReady[i]),
            .issue      (laneIssue),
            .resultValid(laneOutValid[i]),
            .resultReady(laneOutReady[i]),
            .result     (laneResult[i])
        );
    end

    resultCollector uCollector (
        .clk       (clk),
        .rstN      (rstN),
        .laneValid (laneOutValid),
        .laneReady (laneOutReady),
        .laneResult(laneResult),
        .outValid  (outValid),
        .outReady  (outReady),
        .outData   (outData)
    );

endmodule

/* execCluster_settings.svh */
`ifndef EXEC_CLUSTER_SETTINGS_SVH
`define EXEC_CLUSTER_SETTINGS_SVH

// lane count must stay a power of two, pointers wrap by overflow
`define EXEC_LANES    4
`define EXEC_TAG_BITS 6
`define EXEC_XLEN     64

`endif

/* execLane.sv */
`timescale 1ns/10ps

module execLane (
    input  logic            clk,
    input  logic            rstN,
    input  logic            issueValid,
    output logic            issueReady,
    input  execPkg::issueT  issue,
    output logic            resultValid,
    input  logic            resultReady,
    output execPkg::resultT result
);

    execPkg::ctrlT   ctrl;
    execPkg::xlenT   imm;
    execPkg::xlenT   opA;
    execPkg::xlenT   opB;
    execPkg::xlenT   aluResult;
    logic            branchTaken;
    execPkg::xlenT   linkPc;
    execPkg::resultT nextResult;
    logic            fullQ;
    execPkg::resultT resultQ;

    instDecoder uDecoder (
        .inst(issue.inst),
        .ctrl(ctrl),
        .imm (imm)
    );

    assign opA = ctrl.selA ? issue.pc : issue.rs1Val;
    assign opB = ctrl.selB ? imm : issue.rs2Val;

    intAlu uAlu (
        .aluOp      (ctrl.aluOp),
        .a          (opA),
        .b          (opB),
        .wordOp     (ctrl.wordOp),
        .rs1To32    (ctrl.rs1To32),
        .branchFunct(ctrl.branchFunct),
        .result     (aluResult),
        .branchTaken(branchTaken)
    );

    assign linkPc = issue.pc + execPkg::xlenT'(4);

    always_comb begin
        nextResult = '0;
        nextResult.tag = issue.tag;
        nextResult.rdValue = ctrl.wbSel ? linkPc : aluResult;
        nextResult.writeRd = ctrl.writeRd;
        if (ctrl.writeMask != 8'h00 || ctrl.readBytes != 4'h0)
            nextResult.memAddr = aluResult;
        nextResult.writeMask = ctrl.writeMask;
        nextResult.readBytes = ctrl.readBytes;
        nextResult.readSigned = ctrl.readSigned;
        nextResult.redirect = ctrl.isJump || (ctrl.isBranch && branchTaken);
        if (ctrl.jumpReg)
            nextResult.targetPc = aluResult & ~execPkg::xlenT'(1); // jalr drops bit 0
        else if (ctrl.isJump || ctrl.isBranch)
            nextResult.targetPc = issue.pc + imm;
        nextResult.illegal = ctrl.illegal;
    end

    assign issueReady = !fullQ || resultReady; // empty or draining this cycle

    always_ff @(posedge clk) begin
        if (!rstN)
            fullQ <= 1'b0;
        else if (issueValid && issueReady)
            fullQ <= 1'b1;
        else if (resultReady)
            fullQ <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (issueValid && issueReady)
            resultQ <= nextResult;
    end

    assign resultValid = fullQ;
    assign result = resultQ;

    holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        resultValid && !resultReady |=> resultValid && $stable(result));

endmodule

/* execPkg.sv */
`include "execCluster_settings.svh"

package execPkg;

    typedef logic [`EXEC_XLEN-1:0]          xlenT;
    typedef logic [31:0]                    instT;
    typedef logic [`EXEC_TAG_BITS-1:0]      tagT;
    typedef logic [3:0]                     aluOpT;
    typedef logic [$clog2(`EXEC_LANES)-1:0] laneIdxT;

    localparam aluOpT ALU_ADD    = 4'd0;
    localparam aluOpT ALU_SUB    = 4'd1;
    localparam aluOpT ALU_SLL    = 4'd2;
    localparam aluOpT ALU_SLT    = 4'd3;
    localparam aluOpT ALU_SLTU   = 4'd4;
    localparam aluOpT ALU_XOR    = 4'd5;
    localparam aluOpT ALU_SRL    = 4'd6;
    localparam aluOpT ALU_SRA    = 4'd7;
    localparam aluOpT ALU_OR     = 4'd8;
    localparam aluOpT ALU_AND    = 4'd9;
    localparam aluOpT ALU_PASS_B = 4'd10; // lui
    localparam aluOpT ALU_NONE   = 4'd15;

    typedef struct packed {
        instT inst;
        xlenT pc;
        xlenT rs1Val;
        xlenT rs2Val;
        tagT  tag;
    } issueT;

    typedef struct packed {
        aluOpT      aluOp;
        logic       selA;        // 0 rs1, 1 pc
        logic       selB;        // 0 rs2, 1 imm
        logic       wordOp;
        logic       rs1To32;
        logic       writeRd;
        logic       wbSel;       // 0 alu, 1 pc+4
        logic [7:0] writeMask;
        logic [3:0] readBytes;
        logic       readSigned;
        logic       isBranch;
        logic [2:0] branchFunct;
        logic       isJump;
        logic       jumpReg;     // jalr
        logic       illegal;
    } ctrlT;

    typedef struct packed {
        tagT        tag;
        xlenT       rdValue;
        logic       writeRd;
        xlenT       memAddr;
        logic [7:0] writeMask;
        logic [3:0] readBytes;
        logic       readSigned;
        logic       redirect;
        xlenT       targetPc;
        logic       illegal;
    } resultT;

endpackage

/* flist.f */
+incdir+.
execPkg.sv
instDecoder.sv
intAlu.sv
execLane.sv
laneDispatcher.sv
resultCollector.sv
execCluster.sv
tbClock.sv
tbExecCluster.sv

/* instDecoder.sv */
`timescale 1ns/10ps

module instDecoder (
    input  execPkg::instT inst,
    output execPkg::ctrlT ctrl,
    output execPkg::xlenT imm
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          rTypeBad;
    execPkg::xlenT immI;
    execPkg::xlenT immS;
    execPkg::xlenT immB;
    execPkg::xlenT immU;
    execPkg::xlenT immJ;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign immI = {{52{inst[31]}}, inst[31:20]};
    assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // only sub/sra variants may carry 0x20, M-extension funct7 falls in here
    assign rTypeBad = (funct7 != 7'h00) &&
                      !(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = execPkg::ALU_NONE;
        imm = '0;
        case (opcode)
            7'b0110011: begin // OP
                ctrl.writeRd = 1'b1;
                ctrl.illegal = rTypeBad;
                case (funct3)
                    3'b000: ctrl.aluOp = funct7[5] ? execPkg::ALU_SUB : execPkg::ALU_ADD;
                    3'b001: ctrl.aluOp = execPkg::ALU_SLL;
                    3'b010: ctrl.aluOp = execPkg::ALU_SLT;
                    3'b011: ctrl.aluOp = execPkg::ALU_SLTU;
                    3'b100: ctrl.aluOp = execPkg::ALU_XOR;
                    3'b101: ctrl.aluOp = funct7[5] ? execPkg::ALU_SRA : execPkg::ALU_SRL;
                    3'b110: ctrl.aluOp = execPkg::ALU_OR;
                    default: ctrl.aluOp = execPkg::ALU_AND;
                endcase
            end
            7'b0010011: begin // OP-IMM
                ctrl.selB = 1'b1;
                ctrl.writeRd = 1'b1;
                imm = immI;
                case (funct3)
                    3'b000: ctrl.aluOp = execPkg::ALU_ADD;
                    3'b001: begin
                        ctrl.aluOp = execPkg::ALU_SLL;
                        ctrl.illegal = (funct7[6:1] != 6'h00);
                    end
                    3'b010: ctrl.aluOp = execPkg::ALU_SLT;
                    3'b011: ctrl.aluOp = execPkg::ALU_SLTU;
                    3'b100: ctrl.aluOp = execPkg::ALU_XOR;
                    3'b101: begin // 6-bit shamt, funct7[0] is shamt[5]
                        ctrl.aluOp = funct7[5] ? execPkg::ALU_SRA : execPkg::ALU_SRL;
                        ctrl.illegal = (funct7[6:1] != 6'h00) && (funct7[6:1] != 6'h10);
                    end
                    3'b110: ctrl.aluOp = execPkg::ALU_OR;
                    default: ctrl.aluOp = execPkg::ALU_AND;
                endcase
            end
            7'b0010111: begin // auipc
                ctrl.selA = 1'b1;
                ctrl.selB = 1'b1;
                ctrl.writeRd = 1'b1;
                ctrl.aluOp = execPkg::ALU_ADD;
                imm = immU;
            end
            7'b0000011: begin // loads, address only
                ctrl.selB = 1'b1;
                ctrl.writeRd = 1'b1;
                ctrl.aluOp = execPkg::ALU_ADD;
                ctrl.readBytes = 4'h1 << funct3[1:0];
                ctrl.readSigned = !funct3[2];
                ctrl.illegal = (funct3 == 3'b111);
                imm = immI;
            end
            7'b0110111: begin // lui
                ctrl.selB = 1'b1;
                ctrl.writeRd = 1'b1;
                ctrl.aluOp = execPkg::ALU_PASS_B;
                imm = immU;
            end
            7'b1101111: begin // jal
                ctrl.selA = 1'b1;
                ctrl.selB = 1'b1;
                ctrl.writeRd = 1'b1;
                ctrl.wbSel = 1'b1;
                ctrl.isJump = 1'b1;
                ctrl.aluOp = execPkg::ALU_ADD;
                imm = immJ;
            end
            7'b0100011: begin // stores
                ctrl.selB = 1'b1;
                ctrl.aluOp = execPkg::ALU_ADD;
                ctrl.writeMask = 8'((16'h1 << (4'h1 << funct3[1:0])) - 16'h1);
                ctrl.illegal = funct3[2];
                imm = immS;
            end
            7'b0111011: begin // OP-32
                ctrl.wordOp = 1'b1;
                ctrl.writeRd = 1'b1;
                ctrl.illegal = rTypeBad;
                case (funct3)
                    3'b000: ctrl.aluOp = funct7[5] ? execPkg::ALU_SUB : execPkg::ALU_ADD;
                    3'b001: ctrl.aluOp = execPkg::ALU_SLL;
                    3'b101: begin
                        ctrl.rs1To32 = 1'b1;
                        ctrl.aluOp = funct7[5] ? execPkg::ALU_SRA : execPkg::ALU_SRL;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            7'b0011011: begin // OP-IMM-32
                ctrl.selB = 1'b1;
                ctrl.wordOp = 1'b1;
                ctrl.writeRd = 1'b1;
                imm = immI;
                case (funct3)
                    3'b000: ctrl.aluOp = execPkg::ALU_ADD;
                    3'b001: begin
                        ctrl.aluOp = execPkg::ALU_SLL;
                        ctrl.illegal = (funct7 != 7'h00);
                    end
                    3'b101: begin
                        ctrl.rs1To32 = 1'b1;
                        ctrl.aluOp = funct7[5] ? execPkg::ALU_SRA : execPkg::ALU_SRL;
                        ctrl.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            7'b1100111: begin // jalr
                ctrl.selB = 1'b1;
                ctrl.writeRd = 1'b1;
                ctrl.wbSel = 1'b1;
                ctrl.isJump = 1'b1;
                ctrl.jumpReg = 1'b1;
                ctrl.aluOp = execPkg::ALU_ADD;
                ctrl.illegal = (funct3 != 3'b000);
                imm = immI;
            end
            7'b1100011: begin // branches compare rs1/rs2
                ctrl.isBranch = 1'b1;
                ctrl.branchFunct = funct3;
                ctrl.illegal = (funct3[2:1] == 2'b01);
                imm = immB;
            end
            default: ctrl.illegal = 1'b1; // system, fence, anything else
        endcase
        if (ctrl.illegal) begin
            ctrl = '0;
            ctrl.aluOp = execPkg::ALU_NONE;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

/* intAlu.sv */
`timescale 1ns/10ps

module intAlu (
    input  execPkg::aluOpT aluOp,
    input  execPkg::xlenT  a,
    input  execPkg::xlenT  b,
    input  logic           wordOp,
    input  logic           rs1To32,
    input  logic [2:0]     branchFunct,
    output execPkg::xlenT  result,
    output logic           branchTaken
);

    execPkg::xlenT opA;
    execPkg::xlenT raw;
    logic [5:0]    shamt;

    // srlw needs zeros above bit 31, sraw needs the word's own sign
    always_comb begin
        opA = a;
        if (rs1To32) begin
            if (aluOp == execPkg::ALU_SRA)
                opA = {{32{a[31]}}, a[31:0]};
            else
                opA = {32'b0, a[31:0]};
        end
    end

    assign shamt = wordOp ? {1'b0, b[4:0]} : b[5:0];

    always_comb begin
        case (aluOp)
            execPkg::ALU_ADD:    raw = opA + b;
            execPkg::ALU_SUB:    raw = opA - b;
            execPkg::ALU_SLL:    raw = opA << shamt;
            execPkg::ALU_SLT:    raw = {63'b0, $signed(opA) < $signed(b)};
            execPkg::ALU_SLTU:   raw = {63'b0, opA < b};
            execPkg::ALU_XOR:    raw = opA ^ b;
            execPkg::ALU_SRL:    raw = opA >> shamt;
            execPkg::ALU_SRA:    raw = $signed(opA) >>> shamt;
            execPkg::ALU_OR:     raw = opA | b;
            execPkg::ALU_AND:    raw = opA & b;
            execPkg::ALU_PASS_B: raw = b;
            default:             raw = '0;
        endcase
    end

    assign result = wordOp ? {{32{raw[31]}}, raw[31:0]} : raw;

    always_comb begin
        case (branchFunct)
            3'b000:  branchTaken = (a == b);
            3'b001:  branchTaken = (a != b);
            3'b100:  branchTaken = ($signed(a) < $signed(b));
            3'b101:  branchTaken = ($signed(a) >= $signed(b));
            3'b110:  branchTaken = (a < b);
            3'b111:  branchTaken = (a >= b);
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

/* laneDispatcher.sv */
`timescale 1ns/10ps
`include "execCluster_settings.svh"

module laneDispatcher (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   inValid,
    output logic                   inReady,
    input  execPkg::issueT         inData,
    output logic [`EXEC_LANES-1:0] laneValid,
    input  logic [`EXEC_LANES-1:0] laneReady,
    output execPkg::issueT         laneData
);

    execPkg::laneIdxT issuePtr;

    always_comb begin
        laneValid = '0;
        laneValid[issuePtr] = inValid;
    end

    assign inReady = laneReady[issuePtr];
    assign laneData = inData; // valid picks the lane on the shared bus

    always_ff @(posedge clk) begin
        if (!rstN)
            issuePtr <= '0;
        else if (inValid && inReady)
            issuePtr <= issuePtr + 1'b1; // wraps at lane count
    end

    // an offer waiting on a busy lane stays on that lane unchanged
    offerHeld: assert property (@(posedge clk) disable iff (!rstN)
        inValid && !inReady |=> laneValid == $past(laneValid) && $stable(laneData));

endmodule

/* resultCollector.sv */
`timescale 1ns/10ps
`include "execCluster_settings.svh"

module resultCollector (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`EXEC_LANES-1:0] laneValid,
    output logic [`EXEC_LANES-1:0] laneReady,
    input  execPkg::resultT        laneResult [`EXEC_LANES],
    output logic                   outValid,
    input  logic                   outReady,
    output execPkg::resultT        outData
);

    execPkg::laneIdxT drainPtr;

    // drainPtr always points at the oldest result
    assign outValid = laneValid[drainPtr];
    assign outData = laneResult[drainPtr];

    always_comb begin
        laneReady = '0;
        laneReady[drainPtr] = outValid && outReady;
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            drainPtr <= '0;
        else if (outValid && outReady)
            drainPtr <= drainPtr + 1'b1;
    end

    // an empty oldest lane means nothing is in flight
    oldestFirst: assert property (@(posedge clk) disable iff (!rstN)
        !laneValid[drainPtr] |-> laneValid == '0);

endmodule

/* runSim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbExecCluster -f flist.f -o simExec

out="$(./obj_dir/simExec)"
echo "$out"
grep -q "Result: PASSED" <<< "$out"

/* tbClock.sv */
`timescale 1ns/10ps

module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

/* tbExecCluster.sv */
`timescale 1ns/10ps
`include "execCluster_settings.svh"

module tbExecCluster;

    localparam int totalPackets = 181;
    localparam int watchdogCycles = totalPackets * 20 + 200;

    logic clk;
    logic rstN;
    logic inValid;
    logic inReady;
    logic outValid;
    logic outReady;
    execPkg::issueT  inData;
    execPkg::resultT outData;
    execPkg::resultT expQ[$];
    integer seed = 76370;
    int valueErrors = 0;
    int protocolErrors = 0;
    int cycle = 0;
    int acceptCount = 0;
    int stallAccepts = 0;
    int streamCount = 0;
    int lastAccept = 0;
    int acceptCycle [64];
    logic randomReady = 1'b0;
    logic randomBit = 1'b0;
    logic readyLevel = 1'b1;
    logic checkLatency = 1'b0;
    execPkg::tagT nextTag = '0;

    tbClock uClock (.clk(clk), .rstN(rstN));

    execCluster dut (.clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady),
        .inData(inData), .outValid(outValid), .outReady(outReady), .outData(outData));

    assign outReady = randomReady ? randomBit : readyLevel;

    always @(negedge clk) begin
        if (randomReady)
            randomBit = $random(seed) & 1;
    end

    function automatic execPkg::xlenT aluModel(logic [2:0] f3, logic alt, logic word,
                                               execPkg::xlenT a, execPkg::xlenT b);
        logic [5:0] sh;
        logic signed [31:0] aw;
        execPkg::xlenT r;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        aw = a[31:0];
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: r = (a < b) ? 64'd1 : 64'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (word && alt)
                    r = 64'(aw >>> sh); // word view of rs1
                else if (word)
                    r = 64'(a[31:0] >> sh);
                else if (alt)
                    r = $signed(a) >>> sh;
                else
                    r = a >> sh;
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if (word) r = {{32{r[31]}}, r[31:0]};
        return r;
    endfunction

    function automatic execPkg::resultT expectResult(execPkg::issueT p);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        execPkg::xlenT immI;
        execPkg::xlenT immS;
        execPkg::xlenT immB;
        execPkg::xlenT immU;
        execPkg::xlenT immJ;
        logic taken;
        execPkg::resultT e;
        opc = p.inst[6:0];
        f3 = p.inst[14:12];
        f7 = p.inst[31:25];
        immI = {{52{p.inst[31]}}, p.inst[31:20]};
        immS = {{52{p.inst[31]}}, p.inst[31:25], p.inst[11:7]};
        immB = {{52{p.inst[31]}}, p.inst[7], p.inst[30:25], p.inst[11:8], 1'b0};
        immU = {{32{p.inst[31]}}, p.inst[31:12], 12'b0};
        immJ = {{44{p.inst[31]}}, p.inst[19:12], p.inst[20], p.inst[30:21], 1'b0};
        e = '0;
        e.tag = p.tag;
        e.illegal = 1'b1;
        case (opc)
            7'h33, 7'h3b: if ((f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
                              && (opc == 7'h33 || f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)) begin
                e.illegal = 1'b0;
                e.writeRd = 1'b1;
                e.rdValue = aluModel(f3, f7[5], opc[3], p.rs1Val, p.rs2Val);
            end
            7'h13, 7'h1b: if (opc == 7'h13 || f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5) begin
                e.illegal = 1'b0;
                e.writeRd = 1'b1;
                e.rdValue = aluModel(f3, f3 == 3'd5 && f7[5], opc[3], p.rs1Val, immI);
            end
            7'h37, 7'h17: begin
                e.illegal = 1'b0;
                e.writeRd = 1'b1;
                e.rdValue = opc[5] ? immU : p.pc + immU;
            end
            7'h03: if (f3 != 3'd7) begin
                e.illegal = 1'b0;
                e.writeRd = 1'b1;
                e.memAddr = p.rs1Val + immI;
                e.readBytes = (f3[1:0] == 0) ? 4'd1 : (f3[1:0] == 1) ? 4'd2 :
                              (f3[1:0] == 2) ? 4'd4 : 4'd8;
                e.readSigned = !f3[2];
            end
            7'h23: if (!f3[2]) begin
                e.illegal = 1'b0;
                e.memAddr = p.rs1Val + immS;
                e.writeMask = (f3 == 0) ? 8'd1 : (f3 == 1) ? 8'd3 : (f3 == 2) ? 8'd15 : 8'd255;
            end
            7'h6f, 7'h67: if (opc == 7'h6f || f3 == 3'd0) begin
                e.illegal = 1'b0;
                e.writeRd = 1'b1;
                e.rdValue = p.pc + 64'd4;
                e.redirect = 1'b1;
                e.targetPc = opc[3] ? p.pc + immJ : (p.rs1Val + immI) & ~64'd1;
            end
            7'h63: if (f3[2:1] != 2'b01) begin
                case (f3)
                    3'd0: taken = p.rs1Val == p.rs2Val;
                    3'd1: taken = p.rs1Val != p.rs2Val;
                    3'd4: taken = $signed(p.rs1Val) < $signed(p.rs2Val);
                    3'd5: taken = $signed(p.rs1Val) >= $signed(p.rs2Val);
                    3'd6: taken = p.rs1Val < p.rs2Val;
                    default: taken = p.rs1Val >= p.rs2Val;
                endcase
                e.illegal = 1'b0;
                e.redirect = taken;
                e.targetPc = p.pc + immB;
            end
            default: e.illegal = 1'b1;
        endcase
        return e;
    endfunction

    task automatic compareWord(string name, execPkg::xlenT expV, execPkg::xlenT actV);
        if (expV !== actV) begin
            $display("Error at %0t: %s expected 0x%h, got 0x%h", $time, name, expV, actV);
            valueErrors++;
        end
    endtask

    task automatic compareTag(string name, execPkg::tagT expV, execPkg::tagT actV);
        if (expV !== actV) begin
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, expV, actV);
            valueErrors++;
        end
    endtask

    task automatic compareFlags(string name, logic [7:0] expV, logic [7:0] actV);
        if (expV !== actV) begin
            $display("Error at %0t: %s expected 0x%h, got 0x%h", $time, name, expV, actV);
            valueErrors++;
        end
    endtask

    task automatic checkResult(execPkg::resultT e, execPkg::resultT a);
        compareTag("tag", e.tag, a.tag);
        compareFlags("writeRd", 8'(e.writeRd), 8'(a.writeRd));
        compareFlags("writeMask", e.writeMask, a.writeMask);
        compareFlags("readBytes", 8'(e.readBytes), 8'(a.readBytes));
        compareFlags("readSigned", 8'(e.readSigned), 8'(a.readSigned));
        compareFlags("redirect", 8'(e.redirect), 8'(a.redirect));
        compareFlags("illegal", 8'(e.illegal), 8'(a.illegal));
        if (e.writeRd && e.readBytes == 0) compareWord("rdValue", e.rdValue, a.rdValue);
        if (e.writeMask != 0 || e.readBytes != 0) compareWord("memAddr", e.memAddr, a.memAddr);
        compareWord("targetPc", e.targetPc, a.targetPc);
    endtask

    // outputs popped before the same edge's input is queued
    always @(posedge clk) begin
        if (rstN) begin
            if (outValid && outReady) begin
                if (expQ.size() == 0) begin
                    $display("Output with tag %0d came out with nothing expected", outData.tag);
                    protocolErrors++;
                end else begin
                    checkResult(expQ.pop_front(), outData);
                    if (checkLatency && cycle != acceptCycle[outData.tag] + 1) begin
                        $display("Result for tag %0d did not leave one cycle after entry",
                                 outData.tag);
                        protocolErrors++;
                    end
                end
            end
            stallAccepts = outReady ? 0 : stallAccepts;
            if (inValid && inReady) begin
                expQ.push_back(expectResult(inData));
                acceptCycle[inData.tag] = cycle;
                if (checkLatency && streamCount > 0 && cycle != lastAccept + 1) begin
                    $display("Packet with tag %0d was not accepted back to back", inData.tag);
                    protocolErrors++;
                end
                streamCount = checkLatency ? streamCount + 1 : 0;
                lastAccept = cycle;
                if (!outReady) begin
                    stallAccepts++;
                    if (stallAccepts > `EXEC_LANES) begin
                        $display("More packets accepted while stalled than there are lanes");
                        protocolErrors++;
                    end
                end
                acceptCount++;
            end
        end
        cycle++;
    end

    function automatic execPkg::xlenT randWord();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic execPkg::instT encR(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc);
        return {f7, 5'd3, 5'd2, f3, 5'd1, opc};
    endfunction

    function automatic execPkg::instT encI(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc);
        return {imm, 5'd2, f3, 5'd1, opc};
    endfunction

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic sendPacket(execPkg::instT inst, execPkg::xlenT rs1, execPkg::xlenT rs2);
        int n;
        n = acceptCount;
        inData = '{inst: inst, pc: randWord() & ~64'd3, rs1Val: rs1, rs2Val: rs2, tag: nextTag};
        nextTag++;
        inValid = 1'b1;
        do @(negedge clk); while (acceptCount == n);
        inValid = 1'b0;
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        while (expQ.size() != 0 && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (expQ.size() != 0) begin
            $display("%0d results never came out", expQ.size());
            protocolErrors++;
            expQ.delete();
        end
    endtask

    task automatic arithmeticOps();
        for (int f = 0; f < 8; f++) begin
            sendPacket(encR(7'h00, 3'(f), 7'h33), randWord(), randWord());
            sendPacket(encI((f == 1 || f == 5) ? 12'($random(seed) & 63) : 12'($random(seed)),
                            3'(f), 7'h13), randWord(), 0);
        end
        sendPacket(encR(7'h20, 3'd0, 7'h33), randWord(), randWord());
        sendPacket(encR(7'h20, 3'd5, 7'h33), randWord(), randWord());
        sendPacket(encI({6'h10, 6'($random(seed))}, 3'd5, 7'h13), randWord(), 0);
        for (int f = 0; f < 6; f += (f == 1) ? 4 : 1) begin
            sendPacket(encR(7'h00, 3'(f), 7'h3b), randWord(), randWord());
            sendPacket(encI(12'($random(seed) & ((f == 0) ? 12'hfff : 12'h1f)), 3'(f), 7'h1b),
                       randWord(), 0);
        end
        sendPacket(encR(7'h20, 3'd0, 7'h3b), randWord(), randWord());
        sendPacket(encR(7'h20, 3'd5, 7'h3b), randWord(), randWord());
        sendPacket(encI({7'h20, 5'($random(seed))}, 3'd5, 7'h1b), randWord(), 0);
        sendPacket(encR(7'h00, 3'd5, 7'h3b), 64'hffff_ffff_8000_0000, 64'd4); // srlw by 4
        sendPacket({20'($random(seed)), 5'd1, 7'h37}, 0, 0);
        sendPacket({20'($random(seed)), 5'd1, 7'h17}, 0, 0);
    endtask

    task automatic memoryOps();
        logic [11:0] imm;
        for (int f = 0; f < 7; f++)
            sendPacket(encI(12'($random(seed)), 3'(f), 7'h03), randWord(), 0);
        for (int f = 0; f < 4; f++) begin
            imm = 12'($random(seed));
            sendPacket({imm[11:5], 5'd3, 5'd2, 3'(f), imm[4:0], 7'h23}, randWord(), randWord());
        end
    endtask

    task automatic controlFlow();
        execPkg::xlenT lhs [5] = '{5, 3, 9, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff};
        execPkg::xlenT rhs [5] = '{5, 9, 3, 1, 0};
        logic [12:0] off;
        logic [20:0] jOff;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) continue;
            for (int k = 0; k < 5; k++) begin
                off = 13'($random(seed)) & 13'h1ffe;
                sendPacket({off[12], off[10:5], 5'd3, 5'd2, 3'(f), off[4:1], off[11], 7'h63},
                           lhs[k], rhs[k]);
            end
        end
        jOff = 21'($random(seed)) & 21'h1ffffe;
        sendPacket({jOff[20], jOff[10:1], jOff[11], jOff[19:12], 5'd1, 7'h6f}, 0, 0);
        sendPacket(encI(12'h7f3, 3'd0, 7'h67), randWord() & ~64'd1, 0); // odd sum
    endtask

    task automatic illegalOps();
        sendPacket(32'h0000_0073, randWord(), randWord()); // ecall
        sendPacket(encR(7'h01, 3'd0, 7'h33), randWord(), randWord()); // mul
        sendPacket(32'h0000_007f, randWord(), randWord());
    endtask

    task automatic orderingUnderStall();
        randomReady = 1'b1;
        for (int i = 0; i < 64; i++) begin
            case ($random(seed) & 3)
                0: sendPacket(encR(7'h00, 3'($random(seed)), 7'h33), randWord(), randWord());
                1: sendPacket(encI(12'($random(seed)), 3'd0, 7'h13), randWord(), 0);
                2: sendPacket(encI(12'($random(seed)), 3'd2, 7'h03), randWord(), 0);
                default: sendPacket({7'h00, 5'd3, 5'd2, 3'd0, 4'h4, 1'b0, 7'h63}, 7, 7);
            endcase
        end
        randomReady = 1'b0;
        readyLevel = 1'b0;
        fork
            repeat (8) sendPacket(encI(12'($random(seed)), 3'd0, 7'h13), randWord(), 0);
            begin
                repeat (12) @(negedge clk);
                if (inReady) begin
                    $display("inReady stayed high with all lanes full");
                    protocolErrors++;
                end
                readyLevel = 1'b1;
            end
        join
        waitDrain();
    endtask

    task automatic backToBack();
        readyLevel = 1'b1;
        checkLatency = 1'b1;
        for (int i = 0; i < 32; i++)
            sendPacket(encR(7'h00, 3'd0, 7'h33), randWord(), randWord());
        waitDrain();
        checkLatency = 1'b0;
    endtask

    initial begin
        inValid = 1'b0;
        inData = '0;
        @(posedge rstN);
        @(negedge clk);
        arithmeticOps();
        memoryOps();
        controlFlow();
        illegalOps();
        waitDrain();
        orderingUnderStall();
        backToBack();
        repeat (4) @(negedge clk);
        $display("Checks done: %0d value errors, %0d protocol errors",
                 valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout after %0d cycles with the tests still running", watchdogCycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule
